// File: include/rt_cfg.svh
`ifndef RT_CFG_SVH
`define RT_CFG_SVH

// Ray ID width, sized for the ray memory
`define RT_RAY_ID_W 9

// Ray memory entries, one per ray ID
`define RT_RAY_DEPTH 512

// Shading pipe stages
`define RT_PIPE_DEPTH 2

// Join queue entries
`define RT_QUEUE_DEPTH 3

`endif

// File: list.f
+incdir+include
rtl/rt_pkg.sv
rtl/shade_if.sv
rtl/ray_store.sv
rtl/shade_pipe.sv
rtl/hit_join.sv
rtl/dirpint.sv
tests/dirpint_tb.sv

// File: rtl/dirpint.sv
`timescale 1ns/1ps
`default_nettype none

module dirpint (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  shade_valid,
  input  rt_pkg::shade_rec_t    shade_rec,
  output logic                  shade_stall,
  input  logic                  ray_we,
  input  rt_pkg::ray_id_t       ray_waddr,
  input  rt_pkg::ray_vec_t      ray_wdata,
  input  logic                  direct_stall,
  output logic                  direct_valid,
  output rt_pkg::calc_direct_t  direct_data,
  input  logic                  reflect_stall,
  output logic                  reflect_valid,
  output rt_pkg::send_reflect_t reflect_data
);
  import rt_pkg::*;

  logic     rd_en;
  ray_id_t  rd_addr;
  ray_vec_t rd_data;  // Geometry for the record in the last pipe stage

  shade_if sif ();

  ray_store store0 (
    .clk     (clk),
    .we      (ray_we),
    .waddr   (ray_waddr),
    .wdata   (ray_wdata),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  shade_pipe pipe0 (
    .clk      (clk),
    .reset    (reset),
    .in_valid (shade_valid),
    .in_rec   (shade_rec),
    .in_stall (shade_stall),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .down     (sif.src)
  );

  hit_join join0 (
    .clk           (clk),
    .reset         (reset),
    .up            (sif.dst),
    .rd_data       (rd_data),
    .direct_stall  (direct_stall),
    .direct_valid  (direct_valid),
    .direct_data   (direct_data),
    .reflect_stall (reflect_stall),
    .reflect_valid (reflect_valid),
    .reflect_data  (reflect_data)
  );

endmodule

`default_nettype wire

// File: rtl/hit_join.sv
`timescale 1ns/1ps
`default_nettype none

`include "rt_cfg.svh"

module hit_join (
  input  logic                  clk,
  input  logic                  reset,
  shade_if.dst                  up,
  input  rt_pkg::ray_vec_t      rd_data,
  input  logic                  direct_stall,
  output logic                  direct_valid,
  output rt_pkg::calc_direct_t  direct_data,
  input  logic                  reflect_stall,
  output logic                  reflect_valid,
  output rt_pkg::send_reflect_t reflect_data
);
  import rt_pkg::*;

  localparam int DEPTH = `RT_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  typedef struct packed {
    shade_rec_t rec;
    ray_vec_t   geo;
  } entry_t;

  entry_t           queue [DEPTH];
  entry_t           head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [1:0]       count;
  logic             empty;
  logic             push;
  logic             pop;
  logic             to_reflect;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Zero-append below each 24-bit component
  function automatic vector_t widen(input vector24_t v);
    vector_t w;
    w.x = {v.x, 8'h00};
    w.y = {v.y, 8'h00};
    w.z = {v.z, 8'h00};
    return w;
  endfunction

  assign empty    = (count == 2'd0);
  assign up.stall = (count == 2'(DEPTH));
  assign push     = up.valid & ~up.stall;

  assign head       = queue[rd_ptr];
  assign to_reflect = head.rec.is_shadow & ~head.rec.is_last;

  // Offer only when every consumer the head needs is ready
  assign direct_valid  = ~empty & ~direct_stall & ~(to_reflect & reflect_stall);
  assign reflect_valid = direct_valid & to_reflect;
  assign pop           = direct_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= 2'd0;
      up.room <= 2'(DEPTH);
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count   <= count + {1'b0, push} - {1'b0, pop};
      up.room <= 2'(DEPTH) - count;  // One cycle behind count
    end
  end

  // Record meets its geometry here
  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr].rec <= up.rec;
      queue[wr_ptr].geo <= rd_data;
    end
  end

  always_comb begin
    direct_data.ray_id    = head.rec.ray_id;
    direct_data.k         = {head.rec.f_color, 8'h00};
    direct_data.n         = widen(head.rec.normal);
    direct_data.p_int     = head.geo.origin;
    direct_data.spec      = head.rec.spec;
    direct_data.is_miss   = head.rec.is_miss;
    direct_data.is_shadow = head.rec.is_shadow;
    direct_data.is_last   = head.rec.is_last;
  end

  always_comb begin
    reflect_data.ray_id = head.rec.ray_id;
    reflect_data.normal = widen(head.rec.normal);
    reflect_data.p_int  = head.geo.origin;
    reflect_data.dir    = head.geo.dir;
  end

endmodule

`default_nettype wire

// File: rtl/ray_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "rt_cfg.svh"

module ray_store (
  input  logic             clk,
  input  logic             we,
  input  rt_pkg::ray_id_t  waddr,
  input  rt_pkg::ray_vec_t wdata,
  input  logic             rd_en,
  input  rt_pkg::ray_id_t  rd_addr,
  output rt_pkg::ray_vec_t rd_data
);
  import rt_pkg::*;

  ray_vec_t mem [`RT_RAY_DEPTH];  // Origin and direction per ray

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, output holds between reads. Same-address write returns old data
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/rt_pkg.sv
`default_nettype none

`include "rt_cfg.svh"

package rt_pkg;

  typedef logic [31:0] float_t;
  typedef logic [23:0] float24_t;  // Truncated float, low mantissa bits dropped
  typedef logic [15:0] float16_t;

  typedef struct packed {
    float_t x;
    float_t y;
    float_t z;
  } vector_t;

  typedef struct packed {
    float24_t x;
    float24_t y;
    float24_t z;
  } vector24_t;

  typedef logic [`RT_RAY_ID_W-1:0] ray_id_t;

  typedef struct packed {
    vector_t origin;  // Intersection point
    vector_t dir;
  } ray_vec_t;

  typedef struct packed {
    ray_id_t   ray_id;
    vector24_t normal;
    float24_t  f_color;
    float16_t  spec;
    logic      is_miss;
    logic      is_shadow;
    logic      is_last;
  } shade_rec_t;

  typedef struct packed {
    ray_id_t  ray_id;
    float_t   k;
    vector_t  n;
    vector_t  p_int;
    float16_t spec;
    logic     is_miss;
    logic     is_shadow;
    logic     is_last;
  } calc_direct_t;

  typedef struct packed {
    ray_id_t ray_id;
    vector_t normal;
    vector_t p_int;
    vector_t dir;
  } send_reflect_t;

endpackage

`default_nettype wire

// File: rtl/shade_if.sv
`timescale 1ns/1ps
`default_nettype none

interface shade_if;
  import rt_pkg::*;

  logic       valid;
  shade_rec_t rec;
  logic       stall;
  logic [1:0] room;  // Free queue slots, one cycle stale

  modport src (
    output valid,
    output rec,
    input  stall,
    input  room
  );

  modport dst (
    input  valid,
    input  rec,
    output stall,
    output room
  );
endinterface

`default_nettype wire

// File: rtl/shade_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "rt_cfg.svh"

module shade_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  rt_pkg::shade_rec_t in_rec,
  output logic               in_stall,
  output logic               rd_en,
  output rt_pkg::ray_id_t    rd_addr,
  shade_if.src               down
);
  import rt_pkg::*;

  localparam int LAST = `RT_PIPE_DEPTH - 1;

  logic [LAST:0] stg_valid;
  logic [LAST:0] stg_ready;  // Stage can take a record this cycle
  shade_rec_t    stg_rec [`RT_PIPE_DEPTH];
  logic          uncounted;  // Pushed last edge, not yet in room
  logic          credit_ok;
  logic          push;

  // Room lags the queue by a cycle, so discount our own last push
  assign credit_ok  = down.room > {1'b0, uncounted};
  assign down.valid = stg_valid[LAST] & credit_ok;
  assign down.rec   = stg_rec[LAST];
  assign push       = down.valid & ~down.stall;

  always_comb begin
    stg_ready[LAST] = ~stg_valid[LAST] | push;
    for (int i = LAST - 1; i >= 0; i--) begin
      stg_ready[i] = ~stg_valid[i] | stg_ready[i + 1];
    end
  end

  assign in_stall = ~stg_ready[0];

  // Geometry read launched as a record enters the final stage
  assign rd_en   = stg_valid[LAST - 1] & stg_ready[LAST];
  assign rd_addr = stg_rec[LAST - 1].ray_id;

  always_ff @(posedge clk) begin
    if (reset) begin
      stg_valid <= '0;
      uncounted <= 1'b0;
    end else begin
      uncounted <= push;
      if (stg_ready[0]) begin
        stg_valid[0] <= in_valid;
      end
      for (int i = 1; i <= LAST; i++) begin
        if (stg_ready[i]) begin
          stg_valid[i] <= stg_valid[i - 1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stg_ready[0]) begin
      stg_rec[0] <= in_rec;
    end
    for (int i = 1; i <= LAST; i++) begin
      if (stg_ready[i]) begin
        stg_rec[i] <= stg_rec[i - 1];
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/dirpint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dirpint_tb;
  import rt_pkg::*;

  logic          clk;
  logic          reset;
  logic          shade_valid;
  shade_rec_t    shade_rec;
  logic          shade_stall;
  logic          ray_we;
  ray_id_t       ray_waddr;
  ray_vec_t      ray_wdata;
  logic          direct_stall;
  logic          direct_valid;
  calc_direct_t  direct_data;
  logic          reflect_stall;
  logic          reflect_valid;
  send_reflect_t reflect_data;

  integer        seed;
  int            errors;
  int            pass_count;
  int            fail_count;
  bit            saw_stall;
  bit            stream_done;
  ray_vec_t      geo_mem [ray_id_t];  // Mirror of the ray memory
  calc_direct_t  exp_d [$];
  send_reflect_t exp_f [$];
  bit            exp_r [$];

  dirpint dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic void expect_rec(input shade_rec_t r, output calc_direct_t d,
                                     output send_reflect_t f, output bit routed);
    ray_vec_t g;
    g = geo_mem[r.ray_id];
    d.ray_id    = r.ray_id;
    d.k         = {r.f_color, 8'h00};
    d.n.x       = {r.normal.x, 8'h00};
    d.n.y       = {r.normal.y, 8'h00};
    d.n.z       = {r.normal.z, 8'h00};
    d.p_int     = g.origin;
    d.spec      = r.spec;
    d.is_miss   = r.is_miss;
    d.is_shadow = r.is_shadow;
    d.is_last   = r.is_last;
    f.ray_id    = r.ray_id;
    f.normal    = d.n;
    f.p_int     = g.origin;
    f.dir       = g.dir;
    routed      = r.is_shadow & ~r.is_last;  // Shadow rays that are not the last
  endfunction

  function automatic ray_vec_t pattern_geo(input ray_id_t id);
    ray_vec_t g;
    g.origin.x = {8'h10, 15'h0, id};
    g.origin.y = {8'h11, 15'h7f0, ~id};
    g.origin.z = {8'h12, 15'h0, id};
    g.dir.x    = {8'h13, 15'h155, id};
    g.dir.y    = {8'h14, 15'h0, ~id};
    g.dir.z    = {8'h15, 15'h2aa, id};
    return g;
  endfunction

  function automatic shade_rec_t make_rec(input ray_id_t id, input logic [7:0] salt,
                                          input logic shadow, input logic last);
    shade_rec_t r;
    r.ray_id    = id;
    r.normal.x  = {salt, 7'h01, id};
    r.normal.y  = {salt, 7'h02, id};
    r.normal.z  = {salt, 7'h03, id};
    r.f_color   = {salt, 7'h04, id};
    r.spec      = {salt, ~salt};
    r.is_miss   = salt[0];
    r.is_shadow = shadow;
    r.is_last   = last;
    return r;
  endfunction

  function automatic bit in_flight(input ray_id_t id);
    foreach (exp_d[i]) begin
      if (exp_d[i].ray_id == id) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic compare_direct(input calc_direct_t got, input calc_direct_t exp);
    if (got !== exp) begin
      $display("Fail %0t: calc-direct ray %0d got %h expected %h", $time, exp.ray_id, got, exp);
      errors++;
    end
  endtask

  task automatic compare_reflect(input send_reflect_t got, input send_reflect_t exp);
    if (got !== exp) begin
      $display("Fail %0t: send-reflect ray %0d got %h expected %h", $time, exp.ray_id, got, exp);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic idle();
    @(negedge clk);
    shade_valid = 1'b0;
    ray_we      = 1'b0;
  endtask

  task automatic write_geo(input ray_id_t id, input ray_vec_t g);
    @(negedge clk);
    shade_valid = 1'b0;
    ray_we      = 1'b1;
    ray_waddr   = id;
    ray_wdata   = g;
    geo_mem[id] = g;
    @(posedge clk);
  endtask

  task automatic send_rec(input shade_rec_t r);
    calc_direct_t  d;
    send_reflect_t f;
    bit            routed;
    int            cycles;
    @(negedge clk);
    ray_we      = 1'b0;
    shade_valid = 1'b1;
    shade_rec   = r;
    #1;
    cycles = 0;
    while (shade_stall) begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > 500) begin
        $display("timed out waiting for shade_stall to drop");
        fail_count++;
        finish_run();
      end
    end
    expect_rec(r, d, f, routed);  // Accepted at the coming edge
    exp_d.push_back(d);
    exp_f.push_back(f);
    exp_r.push_back(routed);
    @(posedge clk);
  endtask

  task automatic wait_drain();
    int cycles;
    idle();
    cycles = 0;
    while (exp_d.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 2000) begin
        $display("timed out waiting for direct_valid");
        fail_count++;
        finish_run();
      end
    end
  endtask

  always @(posedge clk) begin : monitor
    calc_direct_t  d;
    send_reflect_t f;
    bit            routed;
    if (!reset) begin
      if (shade_stall) begin
        saw_stall = 1'b1;
      end
      if (reflect_valid && !direct_valid) begin
        $display("Fail %0t: reflect_valid high without direct_valid", $time);
        errors++;
      end
      if (direct_valid) begin
        if (exp_d.size() == 0) begin
          $display("Fail %0t: unexpected record for ray %0d", $time, direct_data.ray_id);
          errors++;
        end else begin
          d      = exp_d.pop_front();
          f      = exp_f.pop_front();
          routed = exp_r.pop_front();
          compare_direct(direct_data, d);
          if (reflect_valid !== routed) begin
            $display("Fail %0t: reflect_valid is %b for ray %0d", $time, reflect_valid, d.ray_id);
            errors++;
          end else if (routed) begin
            compare_reflect(reflect_data, f);
          end
        end
      end
    end
  end

  initial begin
    int       err0;
    ray_id_t  id;
    ray_vec_t g;
    seed          = 18;
    errors        = 0;
    pass_count    = 0;
    fail_count    = 0;
    saw_stall     = 1'b0;
    stream_done   = 1'b0;
    reset         = 1'b1;
    shade_valid   = 1'b0;
    shade_rec     = '0;
    ray_we        = 1'b0;
    ray_waddr     = '0;
    ray_wdata     = '0;
    direct_stall  = 1'b0;
    reflect_stall = 1'b0;

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      if (direct_valid !== 1'b0 || reflect_valid !== 1'b0 || shade_stall !== 1'b0) begin
        $display("Fail %0t: outputs not idle around reset", $time);
        errors++;
      end
      if (i == 3) begin
        reset = 1'b0;  // Four rising edges seen in reset
      end
    end
    end_test("reset", err0);

    err0 = errors;
    for (int i = 0; i < 32; i++) begin
      write_geo(ray_id_t'(i), pattern_geo(ray_id_t'(i)));
    end
    for (int i = 0; i < 6; i++) begin
      send_rec(make_rec(ray_id_t'((i * 11) % 32), 8'(i + 8'h40), 1'b0, i[0]));
      wait_drain();
    end
    end_test("field merge", err0);

    err0 = errors;
    for (int c = 0; c < 4; c++) begin
      send_rec(make_rec(ray_id_t'(c + 4), 8'(c + 8'h80), c[1], c[0]));
    end
    wait_drain();
    end_test("routing", err0);

    err0 = errors;
    @(negedge clk);
    reflect_stall = 1'b1;
    send_rec(make_rec(9'd12, 8'hc1, 1'b1, 1'b0));
    send_rec(make_rec(9'd13, 8'hc2, 1'b0, 1'b0));
    send_rec(make_rec(9'd14, 8'hc3, 1'b1, 1'b1));
    idle();
    repeat (12) @(negedge clk);  // Observation window under stall
    if (exp_d.size() != 3) begin
      $display("Fail %0t: record delivered while send-reflect was stalled", $time);
      errors++;
    end
    reflect_stall = 1'b0;
    wait_drain();
    end_test("paired back-pressure", err0);

    err0 = errors;
    saw_stall = 1'b0;
    fork
      begin : sender
        shade_rec_t r;
        for (int n = 0; n < 200; n++) begin
          if (($random(seed) & 7) == 0) begin
            id = ray_id_t'($random(seed) & 31);
            g  = {$random(seed), $random(seed), $random(seed),
                  $random(seed), $random(seed), $random(seed)};
            if (!in_flight(id)) begin
              write_geo(id, g);
            end
          end
          r = make_rec(ray_id_t'($random(seed) & 31), 8'($random(seed)),
                       $random(seed) & 1, $random(seed) & 1);
          send_rec(r);
        end
        idle();
        stream_done = 1'b1;
      end
      begin : stall_drive
        int lev_d;
        int lev_r;
        int left;
        lev_d = 4;  // Start fully stalled so the queue backs up
        lev_r = 0;
        left  = 30;
        while (!stream_done) begin
          @(negedge clk);
          if (left == 0) begin
            lev_d = $unsigned($random(seed)) % 5;
            lev_r = $unsigned($random(seed)) % 5;
            left  = 30;
          end
          left--;
          direct_stall  = ($unsigned($random(seed)) % 4) < lev_d;
          reflect_stall = ($unsigned($random(seed)) % 4) < lev_r;
        end
      end
    join
    direct_stall  = 1'b0;
    reflect_stall = 1'b0;
    wait_drain();
    if (!saw_stall) begin
      $display("shade_stall never rose during the random stream");
      errors++;
    end
    end_test("random stream", err0);

    finish_run();
  end

endmodule

`default_nettype wire
